// File: Makefile
VERILATOR ?= verilator
TOP       := simd_mult_tb
FILELIST  := simd_mult_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
PASS_MSG  := Regression passed

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: simd_mult_top.f
src/rpm_pkg.sv
src/cla4_adder.sv
src/pp_multiplier_8.sv
src/mult_lane.sv
src/lane_combiner.sv
src/simd_mult_top.sv
tests/simd_mult_tb.sv

// File: src/cla4_adder.sv
`timescale 1ns/100ps

module cla4_adder (
  input  logic [3:0] x,
  input  logic [3:0] y,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       cout
);

  logic [3:0] g;
  logic [3:0] p;
  logic [3:0] c;

  assign g = x & y;  // generate
  assign p = x ^ y;  // propagate

  // flat lookahead, no ripple between bits
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);
  assign cout = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0])
              | (p[3] & p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

endmodule

// File: src/lane_combiner.sv
`timescale 1ns/100ps

module lane_combiner (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        lo_valid,
  input  logic [rpm_pkg::prod_w-1:0]  lo_product,
  input  rpm_pkg::mult_mode_e         lo_mode,
  input  logic                        hi_valid,
  input  logic [rpm_pkg::prod_w-1:0]  hi_product,
  output logic                        out_valid,
  output rpm_pkg::result_u            result
);

  rpm_pkg::result_u result_d;

  always_comb begin
    if (lo_mode == rpm_pkg::mode_full) begin
      // hi lane weighs 2^8, sum fits in 24 bits
      result_d.value = {{rpm_pkg::prod_w{1'b0}}, lo_product}
                     + {{rpm_pkg::lane_w{1'b0}}, hi_product, {rpm_pkg::lane_w{1'b0}}};
    end else begin
      result_d.lanes.hi = hi_product;
      result_d.lanes.lo = lo_product;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= lo_valid & hi_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lo_valid) begin
      result <= result_d;
    end
  end

  // both lanes sample the same strobe, so they must stay in step
  a_lanes_aligned : assert property (@(posedge clk) disable iff (!arst_n)
    lo_valid == hi_valid)
    else $error("lane valid flags out of step");

endmodule

// File: src/mult_lane.sv
`timescale 1ns/100ps

module mult_lane #(
  parameter int LANE_IDX = 0
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  rpm_pkg::mult_mode_e         mode,
  input  rpm_pkg::operand_u           a,
  input  rpm_pkg::operand_u           b,
  output logic                        lane_valid,
  output logic [rpm_pkg::prod_w-1:0]  lane_product,
  output rpm_pkg::mult_mode_e         lane_mode
);

  logic [rpm_pkg::lane_w-1:0] op_x;
  logic [rpm_pkg::lane_w-1:0] op_y;
  logic [rpm_pkg::prod_w-1:0] product;
  logic [rpm_pkg::prod_w-1:0] x_ext;
  logic [rpm_pkg::prod_w-1:0] y_ext;

  if (LANE_IDX == 0) begin : g_lane_lo
    assign op_x = a.lanes.lo;
    assign op_y = b.lanes.lo;
  end else begin : g_lane_hi
    assign op_x = a.lanes.hi;
    assign op_y = (mode == rpm_pkg::mode_dual) ? b.lanes.hi : b.lanes.lo;  // full mode shares b.lo
  end

  pp_multiplier_8 mult_inst (
    .x       (op_x),
    .y       (op_y),
    .product (product)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      lane_product <= product;
      lane_mode    <= mode;
    end
  end

  assign x_ext = {{(rpm_pkg::prod_w - rpm_pkg::lane_w){1'b0}}, op_x};
  assign y_ext = {{(rpm_pkg::prod_w - rpm_pkg::lane_w){1'b0}}, op_y};

  // checks the whole partial product tree against a plain multiply
  a_lane_product : assert property (@(posedge clk) disable iff (!arst_n)
    lane_valid |-> lane_product == $past(x_ext) * $past(y_ext))
    else $error("lane %0d product mismatch", LANE_IDX);

endmodule

// File: src/pp_multiplier_8.sv
`timescale 1ns/100ps

module pp_multiplier_8 (
  input  logic [rpm_pkg::lane_w-1:0] x,
  input  logic [rpm_pkg::lane_w-1:0] y,
  output logic [rpm_pkg::prod_w-1:0] product
);

  logic [rpm_pkg::lane_w-1:0] pp [rpm_pkg::lane_w];  // pp[i][j] has weight i+j

  logic [3:0] s1, s2, s3, s4, s5, s6, s7, s8, s9;
  logic       c1, c2, c3, c4, c5, c6, c7, c8, c9;

  logic sa, sb, sc, sd, se, sf;
  logic ca, cb, cc, cd, ce, cf;

  logic [13:0] row_a;
  logic [13:0] row_b;
  logic [13:0] fin_g;
  logic [13:0] fin_p;
  logic [14:0] fin_c;

  for (genvar i = 0; i < rpm_pkg::lane_w; i++) begin : g_pp
    assign pp[i] = y & {rpm_pkg::lane_w{x[i]}};
  end

  // first layer, raw partial products only
  cla4_adder cla01_inst (  // weights 2..5
    .x    (pp[0][5:2]),
    .y    (pp[1][4:1]),
    .cin  (pp[2][0]),
    .sum  (s1),
    .cout (c1)
  );

  cla4_adder cla02_inst (  // weights 6..9
    .x    ({pp[2][7], pp[1][7], pp[0][7:6]}),
    .y    ({pp[3][6], pp[2][6], pp[1][6:5]}),
    .cin  (pp[6][0]),
    .sum  (s2),
    .cout (c2)
  );

  cla4_adder cla03_inst (  // weights 4..7
    .x    (pp[2][5:2]),
    .y    (pp[3][4:1]),
    .cin  (pp[4][0]),
    .sum  (s3),
    .cout (c3)
  );

  cla4_adder cla04_inst (  // weights 6..9
    .x    (pp[4][5:2]),
    .y    (pp[5][4:1]),
    .cin  (s2[0]),
    .sum  (s4),
    .cout (c4)
  );

  cla4_adder cla05_inst (  // weights 10..13
    .x    ({pp[6][7], pp[5][7], pp[4][7:6]}),
    .y    ({pp[7][6], pp[6][6], pp[5][6:5]}),
    .cin  (pp[3][7]),
    .sum  (s5),
    .cout (c5)
  );

  cla4_adder cla06_inst (  // weights 8..11
    .x    (pp[6][5:2]),
    .y    (pp[7][4:1]),
    .cin  (pp[3][5]),
    .sum  (s6),
    .cout (c6)
  );

  // second layer merges first layer sums
  cla4_adder cla07_inst (  // weights 3..6
    .x    ({c1, s1[3:1]}),
    .y    ({s9[1:0], s3[0], pp[2][1]}),
    .cin  (pp[3][0]),
    .sum  (s7),
    .cout (c7)
  );

  cla4_adder cla08_inst (  // weights 7..10
    .x    ({s5[0], s6[1], s2[2:1]}),
    .y    ({s6[2], s4[3], s6[0], pp[6][1]}),
    .cin  (pp[7][0]),
    .sum  (s8),
    .cout (c8)
  );

  cla4_adder cla09_inst (  // weights 5..8
    .x    ({c3, s3[3:2], pp[4][1]}),
    .y    ({s4[2:0], s3[1]}),
    .cin  (pp[5][0]),
    .sum  (s9),
    .cout (c9)
  );

  // leftover columns, weight 7 to 12
  assign sa = s8[0] ^ s9[2] ^ c7;
  assign ca = (s8[0] & s9[2]) | (s8[0] & c7) | (s9[2] & c7);
  assign sb = s8[1] ^ s9[3];
  assign cb = s8[1] & s9[3];
  assign sc = s8[2] ^ s2[3] ^ c9;
  assign cc = (s8[2] & s2[3]) | (s8[2] & c9) | (s2[3] & c9);
  assign sd = s8[3] ^ c4 ^ c2;
  assign cd = (s8[3] & c4) | (s8[3] & c2) | (c4 & c2);
  assign se = s5[1] ^ s6[3] ^ c8;
  assign ce = (s5[1] & s6[3]) | (s5[1] & c8) | (s6[3] & c8);
  assign sf = s5[2] ^ c6 ^ pp[7][5];
  assign cf = (s5[2] & c6) | (s5[2] & pp[7][5]) | (c6 & pp[7][5]);

  // two rows left, bit 0 is weight 1
  assign row_a = {pp[7][7], s5[3], sf, se, sd, sc, sb, sa, s7, s1[0], pp[0][1]};
  assign row_b = {c5, cf, ce, cd, cc, cb, ca, 6'b000000, pp[1][0]};

  assign fin_g    = row_a & row_b;
  assign fin_p    = row_a ^ row_b;
  assign fin_c[0] = 1'b0;

  for (genvar i = 0; i < 14; i++) begin : g_final
    assign fin_c[i+1]   = fin_g[i] | (fin_p[i] & fin_c[i]);
    assign product[i+1] = fin_p[i] ^ fin_c[i];
  end

  assign product[0]  = pp[0][0];
  assign product[15] = fin_c[14];

endmodule

// File: src/rpm_pkg.sv
package rpm_pkg;

  localparam int lane_w = 8;   // one lane operand
  localparam int prod_w = 16;  // one lane product

  typedef enum logic {
    mode_full = 1'b0,  // 16x8 product
    mode_dual = 1'b1   // two 8x8 products
  } mult_mode_e;

  typedef struct packed {
    logic [lane_w-1:0] hi;
    logic [lane_w-1:0] lo;
  } operand_lanes_t;

  typedef union packed {
    logic [2*lane_w-1:0] value;
    operand_lanes_t      lanes;
  } operand_u;

  typedef struct packed {
    logic [prod_w-1:0] hi;
    logic [prod_w-1:0] lo;
  } result_lanes_t;

  // full mode leaves bits 31:24 at zero
  typedef union packed {
    logic [2*prod_w-1:0] value;
    result_lanes_t       lanes;
  } result_u;

endpackage

// File: src/simd_mult_top.sv
`timescale 1ns/100ps

module simd_mult_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  rpm_pkg::mult_mode_e           mode,
  input  logic [2*rpm_pkg::lane_w-1:0]  a,
  input  logic [2*rpm_pkg::lane_w-1:0]  b,
  output logic                          out_valid,
  output logic [2*rpm_pkg::prod_w-1:0]  result
);

  logic                       lo_valid;
  logic [rpm_pkg::prod_w-1:0] lo_product;
  rpm_pkg::mult_mode_e        lo_mode;
  logic                       hi_valid;
  logic [rpm_pkg::prod_w-1:0] hi_product;

  mult_lane #(
    .LANE_IDX (0)
  ) lane_lo_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .mode         (mode),
    .a            (a),
    .b            (b),
    .lane_valid   (lo_valid),
    .lane_product (lo_product),
    .lane_mode    (lo_mode)
  );

  mult_lane #(
    .LANE_IDX (1)
  ) lane_hi_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .mode         (mode),
    .a            (a),
    .b            (b),
    .lane_valid   (hi_valid),
    .lane_product (hi_product),
    .lane_mode    ()  // lane 0 carries the mode
  );

  lane_combiner lane_combiner_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .lo_valid   (lo_valid),
    .lo_product (lo_product),
    .lo_mode    (lo_mode),
    .hi_valid   (hi_valid),
    .hi_product (hi_product),
    .out_valid  (out_valid),
    .result     (result)
  );

endmodule

// File: tests/simd_mult_tb.sv
`timescale 1ns/100ps

module simd_mult_tb;

  localparam int clk_period   = 40;
  localparam int drive_dly    = 5;
  localparam int reset_cycles = 3;
  localparam int n_fixed      = 20;
  localparam int n_rand       = 40;
  localparam int n_total      = n_fixed + n_rand;

  logic                clk;
  logic                arst_n;
  logic                in_valid;
  rpm_pkg::mult_mode_e mode;
  logic [15:0]         a;
  logic [15:0]         b;
  logic                out_valid;
  logic [31:0]         result;

  // stimulus table
  rpm_pkg::mult_mode_e tbl_mode [n_total];
  logic [15:0]         tbl_a    [n_total];
  logic [15:0]         tbl_b    [n_total];
  int                  tbl_gap  [n_total];  // idle cycles after the strobe
  logic [31:0]         tbl_exp  [n_total];
  int                  tbl_idx;
  int                  gap_sum;
  logic                table_ready = 1'b0;

  logic [31:0]         exp_q   [$];
  rpm_pkg::mult_mode_e mode_q  [$];
  int                  cycle_q [$];  // cycle count when each strobe was driven
  int                  cycle_cnt = 0;
  int                  pulse_cnt = 0;
  logic [31:0]         lfsr_state;

  simd_mult_top simd_mult_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .mode      (mode),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  // fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] expected_result(input rpm_pkg::mult_mode_e m,
                                                  input logic [15:0] op_a,
                                                  input logic [15:0] op_b);
    logic [31:0] full_prod;
    logic [15:0] hi_prod;
    logic [15:0] lo_prod;
    full_prod = {16'h0000, op_a} * {24'h000000, op_b[7:0]};  // b.hi unused in full mode
    hi_prod   = {8'h00, op_a[15:8]} * {8'h00, op_b[15:8]};
    lo_prod   = {8'h00, op_a[7:0]} * {8'h00, op_b[7:0]};
    if (m == rpm_pkg::mode_full) begin
      return full_prod;
    end else begin
      return {hi_prod, lo_prod};
    end
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  task automatic add_entry(input rpm_pkg::mult_mode_e m, input logic [15:0] op_a,
                           input logic [15:0] op_b, input int gap);
    tbl_mode[tbl_idx] = m;
    tbl_a[tbl_idx]    = op_a;
    tbl_b[tbl_idx]    = op_b;
    tbl_gap[tbl_idx]  = gap;
    tbl_exp[tbl_idx]  = expected_result(m, op_a, op_b);
    gap_sum           = gap_sum + gap;
    tbl_idx           = tbl_idx + 1;
  endtask

  task automatic fill_table();
    logic [31:0]         bits;
    rpm_pkg::mult_mode_e m;
    logic [15:0]         op_a;
    logic [15:0]         op_b;
    tbl_idx = 0;
    gap_sum = 0;
    add_entry(rpm_pkg::mode_full, 16'hffff, 16'h00ff, 2);  // largest full product
    add_entry(rpm_pkg::mode_full, 16'h0000, 16'h0000, 1);
    add_entry(rpm_pkg::mode_full, 16'hffff, 16'hab00, 1);  // b.lo zero, b.hi ignored
    add_entry(rpm_pkg::mode_full, 16'h0000, 16'h00ff, 1);
    add_entry(rpm_pkg::mode_full, 16'h1234, 16'hff56, 2);
    add_entry(rpm_pkg::mode_full, 16'h8001, 16'h0080, 1);
    add_entry(rpm_pkg::mode_dual, 16'hffff, 16'hffff, 2);
    add_entry(rpm_pkg::mode_dual, 16'h00ff, 16'h00ff, 1);  // hi lane zero
    add_entry(rpm_pkg::mode_dual, 16'hff00, 16'hff00, 1);  // lo lane zero
    add_entry(rpm_pkg::mode_dual, 16'hffff, 16'h00ff, 1);
    add_entry(rpm_pkg::mode_dual, 16'h12ff, 16'h34ff, 1);
    add_entry(rpm_pkg::mode_dual, 16'hff5a, 16'hffa5, 2);
    // back to back, mode flips every cycle
    add_entry(rpm_pkg::mode_full, 16'habcd, 16'h0012, 0);
    add_entry(rpm_pkg::mode_dual, 16'habcd, 16'h0012, 0);
    add_entry(rpm_pkg::mode_full, 16'h00ff, 16'hff01, 0);
    add_entry(rpm_pkg::mode_dual, 16'hff01, 16'h00ff, 0);
    add_entry(rpm_pkg::mode_full, 16'hffff, 16'hffff, 0);
    add_entry(rpm_pkg::mode_dual, 16'hffff, 16'hffff, 0);
    add_entry(rpm_pkg::mode_full, 16'h7f80, 16'h3c81, 0);
    add_entry(rpm_pkg::mode_dual, 16'h7f80, 16'h3c81, 3);
    for (int i = 0; i < n_rand; i++) begin
      random_bits(1, bits);
      m = rpm_pkg::mult_mode_e'(bits[0]);
      random_bits(16, bits);
      op_a = bits[15:0];
      random_bits(16, bits);
      op_b = bits[15:0];
      random_bits(2, bits);
      add_entry(m, op_a, op_b, int'(bits[1:0]));
    end
  endtask

  // called a few ns after a rising edge, returns at the same offset
  task automatic send_request(input int i);
    in_valid = 1'b1;
    mode     = tbl_mode[i];
    a        = tbl_a[i];
    b        = tbl_b[i];
    exp_q.push_back(tbl_exp[i]);
    mode_q.push_back(tbl_mode[i]);
    cycle_q.push_back(cycle_cnt);
    @(posedge clk);
    #drive_dly;
    in_valid = 1'b0;
    a        = ~tbl_a[i];  // idle operands must not reach a result
    b        = ~tbl_b[i];
    repeat (tbl_gap[i]) begin
      @(posedge clk);
      #drive_dly;
    end
  endtask

  always @(negedge clk) begin : monitor_output
    logic [31:0]         exp_val;
    rpm_pkg::mult_mode_e exp_mode;
    int                  exp_cycle;
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("out_valid pulsed with no request in flight");
      end else begin
        exp_val   = exp_q.pop_front();
        exp_mode  = mode_q.pop_front();
        exp_cycle = cycle_q.pop_front();
        pulse_cnt = pulse_cnt + 1;
        check_value("out_valid latency", cycle_cnt - exp_cycle, 2);
        if (exp_mode == rpm_pkg::mode_full) begin
          check_value("result", result, exp_val);
        end else begin
          check_value("result.lanes.lo", {16'h0000, result[15:0]}, {16'h0000, exp_val[15:0]});
          check_value("result.lanes.hi", {16'h0000, result[31:16]},
                      {16'h0000, exp_val[31:16]});
        end
      end
    end else if (out_valid !== 1'b0) begin
      stop_with_failure("out_valid is unknown");
    end
  end

  initial begin : watchdog
    int limit_cycles;
    wait (table_ready === 1'b1);
    limit_cycles = reset_cycles + n_total + gap_sum + 20;
    #(limit_cycles * clk_period);
    stop_with_failure($sformatf("timeout, run did not finish within %0d cycles",
                                limit_cycles));
  end

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    mode       = rpm_pkg::mode_full;
    a          = '0;
    b          = '0;
    lfsr_state = 32'haa07_9ce3;
    fill_table();
    table_ready = 1'b1;
    repeat (reset_cycles) begin
      @(posedge clk);
      #drive_dly;
      check_value("out_valid", {31'h0, out_valid}, 32'h0);
    end
    arst_n = 1'b1;
    for (int i = 0; i < n_total; i++) begin
      send_request(i);
    end
    repeat (4) begin
      @(posedge clk);
    end
    if (pulse_cnt == n_total && exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure($sformatf("expected %0d out_valid pulses but saw %0d",
                                  n_total, pulse_cnt));
    end
  end

endmodule
